//--- verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] xlen_t;     // data word
    typedef logic [31:0] addr_t;     // byte address, pc / iad / dad
    typedef logic [31:0] inst_t;     // raw instruction word
    typedef logic [4:0]  reg_idx_t;  // x0..x31

    // rv32i major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_auipc  = 7'b0010111,
        op_store  = 7'b0100011,
        op_reg    = 7'b0110011,
        op_lui    = 7'b0110111,
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_t;  // fence / system fall through as nop

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and,
        alu_pass_b  // lui, b passes straight through
    } alu_op_t;

    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_kind_t;

    typedef enum logic [1:0] {res_alu, res_mem, res_pc_plus4} result_src_t;

    // matches funct3[1:0] of loads and stores, straight onto the size pins
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } size_t;

    localparam addr_t reset_vector = 32'h0000_0000;  // first fetch address

endpackage

`default_nettype wire

//--- verilog/ctrl_if.sv
`default_nettype none

interface ctrl_if;
    import cpu_pkg::*;

    alu_op_t     alu_ctrl;       // alu operation
    logic        alu_src_imm;    // b = immediate instead of rs2
    logic        a_src_pc;       // a = pc, auipc
    imm_kind_t   imm_kind;       // immediate format
    result_src_t result_src;     // what gets written back
    logic        reg_write;      // rd write enable
    logic        mem_read;       // load
    logic        mem_write;      // store
    logic        load_unsigned;  // lbu / lhu
    size_t       size;           // access width
    logic        is_branch;      // conditional branch
    logic        is_jal;
    logic        is_jalr;

    modport dec (output alu_ctrl, alu_src_imm, a_src_pc, imm_kind, result_src, reg_write,
                 mem_read, mem_write, load_unsigned, size, is_branch, is_jal, is_jalr);
    modport dp  (input  alu_ctrl, alu_src_imm, a_src_pc, imm_kind, result_src, reg_write,
                 mem_read, mem_write, load_unsigned, size, is_branch, is_jal, is_jalr);

endinterface

`default_nettype wire

//--- verilog/decoder.sv
`default_nettype none

module decoder (
    input  wire cpu_pkg::inst_t inst,
    ctrl_if.dec                 ctrl
);
    import cpu_pkg::*;

    logic [2:0] funct3;
    logic       funct7_alt;  // inst[30], sub / sra select

    assign funct3     = inst[14:12];
    assign funct7_alt = inst[30];

    // shared by op and op-imm
    function automatic alu_op_t f3_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  f3_op = alt ? alu_sub : alu_add;
            3'b001:  f3_op = alu_sll;
            3'b010:  f3_op = alu_slt;
            3'b011:  f3_op = alu_sltu;
            3'b100:  f3_op = alu_xor;
            3'b101:  f3_op = alt ? alu_sra : alu_srl;
            3'b110:  f3_op = alu_or;
            default: f3_op = alu_and;
        endcase
    endfunction

    function automatic size_t f3_size(input logic [1:0] f);
        case (f)
            2'b00:   f3_size = size_byte;
            2'b01:   f3_size = size_half;
            default: f3_size = size_word;
        endcase
    endfunction

    always_comb begin
        // nop defaults, nothing written, no bus cycle
        ctrl.alu_ctrl      = alu_add;
        ctrl.alu_src_imm   = 1'b0;
        ctrl.a_src_pc      = 1'b0;
        ctrl.imm_kind      = imm_i;
        ctrl.result_src    = res_alu;
        ctrl.reg_write     = 1'b0;
        ctrl.mem_read      = 1'b0;
        ctrl.mem_write     = 1'b0;
        ctrl.load_unsigned = funct3[2];          // lbu / lhu
        ctrl.size          = f3_size(funct3[1:0]);
        ctrl.is_branch     = 1'b0;
        ctrl.is_jal        = 1'b0;
        ctrl.is_jalr       = 1'b0;
        case (inst[6:0])
            op_lui: begin
                ctrl.alu_ctrl    = alu_pass_b;   // rd = imm
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_kind    = imm_u;
                ctrl.reg_write   = 1'b1;
            end
            op_auipc: begin
                ctrl.a_src_pc    = 1'b1;         // rd = pc + imm
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_kind    = imm_u;
                ctrl.reg_write   = 1'b1;
            end
            op_jal: begin
                ctrl.is_jal      = 1'b1;
                ctrl.imm_kind    = imm_j;
                ctrl.result_src  = res_pc_plus4; // link
                ctrl.reg_write   = 1'b1;
            end
            op_jalr: begin
                ctrl.is_jalr     = 1'b1;         // target from alu, rs1 + imm
                ctrl.alu_src_imm = 1'b1;
                ctrl.result_src  = res_pc_plus4;
                ctrl.reg_write   = 1'b1;
            end
            op_branch: begin
                ctrl.is_branch   = 1'b1;
                ctrl.imm_kind    = imm_b;
                // beq/bne compare by sub, signed and unsigned by slt/sltu
                ctrl.alu_ctrl    = !funct3[2] ? alu_sub : (funct3[1] ? alu_sltu : alu_slt);
            end
            op_load: begin
                ctrl.mem_read    = 1'b1;         // address = rs1 + imm
                ctrl.alu_src_imm = 1'b1;
                ctrl.result_src  = res_mem;
                ctrl.reg_write   = 1'b1;
            end
            op_store: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm_kind    = imm_s;
            end
            op_imm: begin
                ctrl.alu_ctrl    = f3_op(funct3, funct7_alt && funct3 == 3'b101); // srai only
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            op_reg: begin
                ctrl.alu_ctrl    = f3_op(funct3, funct7_alt);
                ctrl.reg_write   = 1'b1;
            end
            default: ;                           // fence, system, unknown
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`default_nettype none

module alu (
    input  wire cpu_pkg::alu_op_t op,
    input  wire cpu_pkg::xlen_t   a,
    input  wire cpu_pkg::xlen_t   b,
    output cpu_pkg::xlen_t        y,
    output logic                  zero
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rv32 shifts use five bits

    always_comb begin
        case (op)
            alu_add:    y = a + b;
            alu_sub:    y = a - b;
            alu_sll:    y = a << shamt;
            alu_slt:    y = {31'b0, $signed(a) < $signed(b)};
            alu_sltu:   y = {31'b0, a < b};
            alu_xor:    y = a ^ b;
            alu_srl:    y = a >> shamt;
            alu_sra:    y = xlen_t'($signed(a) >>> shamt);  // keep sign bit
            alu_or:     y = a | b;
            alu_and:    y = a & b;
            alu_pass_b: y = b;                               // lui
            default:    y = a + b;
        endcase
    end

    // branch logic reads this, equal after sub or "not less" after slt
    assign zero = (y == '0);

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
`default_nettype none

module reg_file (
    input  wire                   clk,
    input  wire                   reset,
    input  wire cpu_pkg::reg_idx_t rs1,
    input  wire cpu_pkg::reg_idx_t rs2,
    output cpu_pkg::xlen_t        rd1,
    output cpu_pkg::xlen_t        rd2,
    input  wire                   we,
    input  wire cpu_pkg::reg_idx_t rd,
    input  wire cpu_pkg::xlen_t   wd
);
    import cpu_pkg::*;

    xlen_t regs [1:31];  // no storage behind x0

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;  // writes to x0 dropped
        end
    end

    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 reads zero
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/ctrl_datapath.sv
`default_nettype none

module ctrl_datapath #(
    parameter cpu_pkg::addr_t reset_pc = cpu_pkg::reset_vector
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire cpu_pkg::inst_t inst,
    input  wire                 acki_n,
    input  wire                 ackd_n,
    ctrl_if.dp                  ctrl,
    input  wire cpu_pkg::xlen_t ddt_in,
    output cpu_pkg::addr_t      pc,
    output cpu_pkg::addr_t      dad,
    output cpu_pkg::xlen_t      store_data,
    output logic                mreq,
    output logic                write,
    output cpu_pkg::size_t      size
);
    import cpu_pkg::*;

    reg_idx_t rs1, rs2, rd;
    xlen_t    rd1, rd2;
    xlen_t    src1, src2;        // register operands after forwarding
    xlen_t    imm;
    xlen_t    alu_a, alu_b, alu_y;
    logic     alu_zero;
    logic     taken;             // branch condition met
    addr_t    pc_plus4, pc_rel, next_pc;
    xlen_t    ex_result;
    logic     stall;             // M waiting on ackd_n
    logic     advance;           // fetch accepted this edge

    reg_idx_t m_rd;
    xlen_t    m_alu;             // alu result, or the address for loads / stores
    xlen_t    m_store;
    logic     m_reg_write, m_mem_read, m_mem_write, m_unsigned;
    size_t    m_size;
    xlen_t    load_ext, wb_data;

    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign rd  = inst[11:7];

    always_comb begin
        case (ctrl.imm_kind)
            imm_s:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            imm_b:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            imm_u:   imm = {inst[31:12], 12'b0};
            imm_j:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = {{20{inst[31]}}, inst[31:20]};  // i type
        endcase
    end

    reg_file regs (
        .clk(clk), .reset(reset),
        .rs1(rs1), .rs2(rs2),
        .rd1(rd1), .rd2(rd2),
        .we(m_reg_write && !stall),  // writeback on the edge M ends
        .rd(m_rd), .wd(wb_data)
    );

    // M destination wins over the register file, m_reg_write already excludes x0
    assign src1 = (m_reg_write && m_rd == rs1) ? wb_data : rd1;
    assign src2 = (m_reg_write && m_rd == rs2) ? wb_data : rd2;

    assign alu_a = ctrl.a_src_pc ? pc : src1;      // auipc
    assign alu_b = ctrl.alu_src_imm ? imm : src2;

    alu exec (
        .op(ctrl.alu_ctrl), .a(alu_a), .b(alu_b),
        .y(alu_y), .zero(alu_zero)
    );

    // funct3 bit 0 inverts, bit 2 flips for the slt based compares
    assign taken = alu_zero ^ inst[12] ^ inst[14];

    assign pc_plus4 = pc + 32'd4;
    assign pc_rel   = pc + imm;                     // jal and branch target

    always_comb begin
        if (ctrl.is_jalr) begin
            next_pc = {alu_y[31:1], 1'b0};          // lsb cleared
        end else if (ctrl.is_jal || (ctrl.is_branch && taken)) begin
            next_pc = pc_rel;
        end else begin
            next_pc = pc_plus4;
        end
    end

    assign ex_result = (ctrl.result_src == res_pc_plus4) ? pc_plus4 : alu_y;  // link or alu

    assign stall   = mreq && ackd_n;
    assign advance = !acki_n && !stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (advance) begin
            pc <= next_pc;  // no bubble after taken jumps
        end
    end

    // M control, bubble when no fetch is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            m_reg_write <= 1'b0;
            m_mem_read  <= 1'b0;
            m_mem_write <= 1'b0;
        end else if (!stall) begin
            m_reg_write <= advance && ctrl.reg_write && (rd != 5'd0);
            m_mem_read  <= advance && ctrl.mem_read;
            m_mem_write <= advance && ctrl.mem_write;
        end
    end

    // M payload
    always_ff @(posedge clk) begin
        if (advance) begin
            m_rd       <= rd;
            m_alu      <= ex_result;
            m_store    <= src2;
            m_size     <= ctrl.size;
            m_unsigned <= ctrl.load_unsigned;
        end
    end

    assign mreq       = m_mem_read || m_mem_write;
    assign write      = m_mem_write;
    assign dad        = m_alu;
    assign size       = m_size;
    assign store_data = m_store;  // right aligned, memory places the bytes

    always_comb begin
        case (m_size)
            size_byte: load_ext = m_unsigned ? {24'b0, ddt_in[7:0]}
                                             : {{24{ddt_in[7]}}, ddt_in[7:0]};
            size_half: load_ext = m_unsigned ? {16'b0, ddt_in[15:0]}
                                             : {{16{ddt_in[15]}}, ddt_in[15:0]};
            default:   load_ext = ddt_in;
        endcase
    end

    assign wb_data = m_mem_read ? load_ext : m_alu;  // load data only valid at ack edge

endmodule

`default_nettype wire

//--- verilog/top.sv
`default_nettype none

module top #(
    parameter cpu_pkg::addr_t reset_pc = cpu_pkg::reset_vector
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 acki_n,
    input  wire                 ackd_n,
    input  wire cpu_pkg::inst_t idt,
    output cpu_pkg::addr_t      iad,
    output cpu_pkg::addr_t      dad,
    output logic                mreq,
    output logic                write,   // store when high
    output cpu_pkg::size_t      size,
    inout  wire cpu_pkg::xlen_t ddt
);
    import cpu_pkg::*;

    xlen_t store_data;

    ctrl_if ctrl ();  // decoded control, current fetch

    decoder dec (
        .inst(idt),
        .ctrl(ctrl.dec)
    );

    ctrl_datapath #(.reset_pc(reset_pc)) datapath (
        .clk(clk), .reset(reset),
        .inst(idt),
        .acki_n(acki_n), .ackd_n(ackd_n),
        .ctrl(ctrl.dp),
        .ddt_in(ddt),          // load data from memory
        .pc(iad),
        .dad(dad),
        .store_data(store_data),
        .mreq(mreq), .write(write),
        .size(size)
    );

    assign ddt = (mreq && write) ? store_data : 'z;  // released unless storing

endmodule

`default_nettype wire

//--- verif/tb_asserts.sv
`default_nettype none

module tb_asserts (
    input wire        clk,
    input wire        reset,
    input wire        mreq,
    input wire        write,
    input wire        ackd_n,
    input wire [31:0] iad,
    input wire [31:0] dad,
    input wire [31:0] ddt,
    input wire [1:0]  size
);

    reset_idle: assert property (@(posedge clk) reset |=> !mreq && !write)
        else $error("data bus active during or right after reset");

    // request held until acknowledged
    hold_req: assert property (@(posedge clk) disable iff (reset)
        mreq && ackd_n |=> $stable(dad) && $stable(write) && $stable(size))
        else $error("data request changed before ackd_n");

    iad_align: assert property (@(posedge clk) disable iff (reset) iad[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    store_drive: assert property (@(posedge clk) disable iff (reset) write |-> !$isunknown(ddt))
        else $error("ddt floating during a store");

endmodule

bind top tb_asserts asserts_inst (
    .clk(clk), .reset(reset), .mreq(mreq), .write(write), .ackd_n(ackd_n),
    .iad(iad), .dad(dad), .ddt(ddt), .size(size)
);

`default_nettype wire

//--- verif/tb_checker.sv
`default_nettype none

module tb_checker #(
    parameter logic [31:0] start_pc = 32'd0,
    parameter logic [31:0] final_pc = 32'd796
) (
    input wire        clk,
    input wire        reset,
    input wire        acki_n,
    input wire        ackd_n,
    input wire        mreq,
    input wire        write,
    input wire [31:0] iad,
    input wire [31:0] dad,
    input wire [31:0] ddt,
    input wire [1:0]  size
);
    logic [31:0] prog [0:255];
    logic [7:0]  mem [0:255];  // data window indexed by the low address byte
    logic [31:0] x [0:31];
    logic [31:0] mpc = start_pc;
    logic [31:0] q_addr [$];  // expected bus cycles in program order
    logic [31:0] q_data [$];
    logic        q_wr [$];
    logic [1:0]  q_size [$];
    int          errors = 0;
    int          fetches = 0;
    int          dut_cycles = 0;
    int          model_cycles = 0;
    logic        done = 1'b0;

    initial begin
        for (int i = 0; i < 32; i++) x[i] = 32'd0;
    end

    function automatic logic [31:0] size_mask(input logic [1:0] s);
        return (s == 2'd0) ? 32'hff : (s == 2'd1) ? 32'hffff : 32'hffff_ffff;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] load_val(input logic [31:0] ea, input logic [2:0] f3);
        logic [7:0]  i;
        logic [31:0] w;
        i = ea[7:0];
        w = {mem[i + 8'd3], mem[i + 8'd2], mem[i + 8'd1], mem[i]};
        case (f3)
            3'd0:    return {{24{w[7]}}, w[7:0]};
            3'd1:    return {{16{w[15]}}, w[15:0]};
            3'd4:    return {24'd0, w[7:0]};
            3'd5:    return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic push_cycle(input logic [31:0] a, input logic w, input logic [1:0] s,
                              input logic [31:0] d);
        q_addr.push_back(a);
        q_wr.push_back(w);
        q_size.push_back(s);
        q_data.push_back(d & size_mask(s));
        model_cycles++;
    endtask

    // one instruction of the reference model
    task automatic execute(input logic [31:0] in);
        logic [31:0] a, b, ii, is, ib, iu, ij, r, ea, npc;
        logic [2:0]  f3;
        logic        wr;
        a   = x[in[19:15]];
        b   = x[in[24:20]];
        f3  = in[14:12];
        ii  = {{20{in[31]}}, in[31:20]};
        is  = {{20{in[31]}}, in[31:25], in[11:7]};
        ib  = {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
        iu  = {in[31:12], 12'd0};
        ij  = {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
        r   = 32'd0;
        wr  = 1'b1;
        npc = mpc + 32'd4;
        case (in[6:0])
            7'h37: r = iu;
            7'h17: r = mpc + iu;
            7'h6f: begin
                r   = mpc + 32'd4;
                npc = mpc + ij;
            end
            7'h67: begin
                r   = mpc + 32'd4;
                npc = (a + ii) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                if (branch_taken(f3, a, b)) npc = mpc + ib;
            end
            7'h03: begin
                ea = a + ii;
                r  = load_val(ea, f3);
                push_cycle(ea, 1'b0, f3[1:0], 32'd0);
            end
            7'h23: begin
                wr = 1'b0;
                ea = a + is;
                mem[ea[7:0]] = b[7:0];
                if (f3[1:0] != 2'd0) mem[ea[7:0] + 8'd1] = b[15:8];
                if (f3[1:0] == 2'd2) begin
                    mem[ea[7:0] + 8'd2] = b[23:16];
                    mem[ea[7:0] + 8'd3] = b[31:24];
                end
                push_cycle(ea, 1'b1, f3[1:0], b);
            end
            7'h13: r = alu_model(f3, in[30] && f3 == 3'd5, a, ii);  // only srai uses bit 30
            7'h33: r = alu_model(f3, in[30], a, b);
            default: wr = 1'b0;                                     // fence, system
        endcase
        if (wr && in[11:7] != 5'd0) x[in[11:7]] = r;
        mpc = npc;
    endtask

    task automatic complete_data();
        logic [31:0] a, d;
        logic [1:0]  s;
        logic        w;
        dut_cycles++;
        if (q_addr.size() == 0) begin
            errors++;
            $display("data cycle at %h started with no load or store pending", dad);
        end else begin
            a = q_addr.pop_front();
            w = q_wr.pop_front();
            s = q_size.pop_front();
            d = q_data.pop_front();
            check("data address", a, dad);
            check("data write", {31'd0, w}, {31'd0, write});
            check("data size", {30'd0, s}, {30'd0, size});
            if (w) check("store data", d, ddt & size_mask(s));
        end
    endtask

    task automatic finish_run();
        done = 1'b1;
        if (q_addr.size() != 0) begin
            errors++;
            $display("final loop reached with %0d data cycles never seen", q_addr.size());
        end
        if (dut_cycles != model_cycles) begin
            errors++;
            $display("data cycle count differs, core %0d, model %0d", dut_cycles, model_cycles);
        end
    endtask

    task automatic report_timeout(input int c);
        errors++;
        $display("timeout after %0d cycles, the program did not reach its final loop", c);
    endtask

    task automatic report();
        $display("checker: %0d fetches, %0d data cycles (model %0d), %0d errors",
                 fetches, dut_cycles, model_cycles, errors);
    endtask

    // bus cycle ending first, then the fetch taken on the same edge
    always @(posedge clk) begin
        if (!reset && !done) begin
            if (mreq && !ackd_n) complete_data();
            if (!acki_n && !(mreq && ackd_n)) begin
                fetches++;
                check("fetch address", mpc, iad);
                if (mpc == final_pc) finish_run();
                else execute(prog[mpc[9:2]]);
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_top.sv
`default_nettype none

module tb_top;
    localparam int          n_inst    = 200;
    localparam int          limit     = n_inst * 8 + 50;  // cycles after reset
    localparam logic [31:0] data_base = 32'h400;          // 256 byte data window
    localparam logic [31:0] start_pc  = cpu_pkg::reset_vector;

    logic        clk = 1'b0;
    logic        reset, acki_n, ackd_n;
    logic [31:0] idt, iad, dad, rdata;
    logic        mreq, write;
    logic [1:0]  size;
    wire  [31:0] ddt;
    logic [31:0] seed = 32'hfdf5;
    logic [31:0] imem [0:255];
    logic [7:0]  dmem [0:255];
    logic        ipend, dpend;  // delay already drawn for the current fetch / data cycle
    logic        ftake, dtake;  // fetch taken / data cycle ended on the last rising edge
    int          idelay, ddelay, cycles;

    top #(.reset_pc(start_pc)) top_inst (
        .clk(clk), .reset(reset), .acki_n(acki_n), .ackd_n(ackd_n),
        .idt(idt), .iad(iad), .dad(dad), .mreq(mreq), .write(write),
        .size(size), .ddt(ddt)
    );

    tb_checker #(.start_pc(start_pc), .final_pc(start_pc + (n_inst - 1) * 4)) chk (
        .clk(clk), .reset(reset), .acki_n(acki_n), .ackd_n(ackd_n), .mreq(mreq),
        .write(write), .iad(iad), .dad(dad), .ddt(ddt), .size(size)
    );

    always #50 clk = ~clk;

    function logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8;  // low bits are weak
    endfunction

    function automatic logic [7:0] fill_byte(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9e37_79b1;  // mixes every address bit
        return h[31:24];
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};  // base always x0
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] o, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] o, input logic [4:0] rd);
        return {o[20], o[10:1], o[11], o[19:12], rd, 7'h6f};
    endfunction

    task automatic gen_program();
        logic [31:0] r, addr, n;
        logic [11:0] sh;
        logic [7:0]  mask;
        logic [4:0]  rd, s1, s2;
        logic [2:0]  f3;
        int          k;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013;  // addi x0, x0, 0
        end
        for (int i = 0; i < n_inst - 1; i++) begin
            r  = lcg();
            rd = 5'(r % 8);            // x0..x7 only for lots of dependencies
            s1 = 5'((r >> 3) % 8);
            s2 = 5'((r >> 6) % 8);
            f3 = r[11:9];
            n  = r % 5;
            k  = 1 + int'((r >> 12) % 5);  // forward jump distance
            if (i + k > n_inst - 1) k = n_inst - 1 - i;
            sh = (f3 == 3'd5) ? {1'b0, r[21], 5'd0, r[29:25]} : {7'd0, r[29:25]};
            case ((lcg() >> 4) % 10)
                0, 1: imem[i] = enc_r(((f3 == 3'd0 || f3 == 3'd5) && r[20]) ? 7'h20 : 7'h00,
                                      s2, s1, f3, rd);
                2, 3: imem[i] = enc_i((f3 == 3'd1 || f3 == 3'd5) ? sh : r[31:20],
                                      s1, f3, rd, 7'h13);
                4: imem[i] = {r[31:12], rd, 7'h37};  // lui
                5: imem[i] = {r[31:12], rd, 7'h17};  // auipc
                6: begin
                    f3   = (n == 3) ? 3'd4 : (n == 4) ? 3'd5 : 3'(n);  // lb lh lw lbu lhu
                    mask = f3[1] ? 8'hfc : f3[0] ? 8'hfe : 8'hff;   // natural alignment
                    addr = data_base + {24'd0, r[23:16] & mask};
                    imem[i] = enc_i(addr[11:0], 5'd0, f3, rd, 7'h03);
                end
                7: begin
                    f3   = 3'(r % 3);
                    mask = f3[1] ? 8'hfc : f3[0] ? 8'hfe : 8'hff;
                    addr = data_base + {24'd0, r[23:16] & mask};
                    imem[i] = enc_s(addr[11:0], s2, f3);
                end
                8: begin
                    n = r % 6;
                    f3 = (n < 2) ? 3'(n) : 3'(n + 2);  // skip the two reserved codes
                    imem[i] = enc_b(13'(k * 4), s2, s1, f3);
                end
                default: begin
                    if (r[20]) imem[i] = enc_j(21'(k * 4), rd);
                    else imem[i] = enc_i(12'(start_pc + (i + k) * 4), 5'd0, 3'd0, rd, 7'h67);
                end
            endcase
        end
        imem[n_inst - 1] = 32'h0000_006f;  // jal x0, 0
    endtask

    assign idt = imem[iad[9:2]];                      // zero wait lookup
    assign ddt = (mreq && !write) ? rdata : 'z;       // memory drives loads only

    always_comb begin
        case (size)
            2'd0:    rdata = {24'd0, dmem[dad[7:0]]};
            2'd1:    rdata = {16'd0, dmem[dad[7:0] + 8'd1], dmem[dad[7:0]]};
            default: rdata = {dmem[dad[7:0] + 8'd3], dmem[dad[7:0] + 8'd2],
                              dmem[dad[7:0] + 8'd1], dmem[dad[7:0]]};
        endcase
    end

    // acks change on the falling edge only
    always @(negedge clk) begin
        if (ftake) ipend = 1'b0;  // next fetch gets a fresh delay
        if (dtake) dpend = 1'b0;
        if (!ipend) begin
            idelay = int'(lcg() % 3);
            ipend  = 1'b1;
        end
        acki_n = (idelay != 0);
        if (idelay != 0) idelay--;
        if (!mreq) begin
            dpend = 1'b0;
        end else if (!dpend) begin
            ddelay = int'(lcg() % 3);
            dpend  = 1'b1;
        end
        ackd_n = !(mreq && ddelay == 0);
        if (mreq && ddelay != 0) ddelay--;
    end

    always @(posedge clk) begin
        ftake = !reset && !acki_n && !(mreq && ackd_n);
        dtake = !reset && mreq && !ackd_n;
        if (!reset) begin
            cycles++;
        end
        if (dtake && write) begin
            dmem[dad[7:0]] = ddt[7:0];
            if (size != 2'd0) dmem[dad[7:0] + 8'd1] = ddt[15:8];
            if (size == 2'd2) begin
                dmem[dad[7:0] + 8'd2] = ddt[23:16];
                dmem[dad[7:0] + 8'd3] = ddt[31:24];
            end
        end
    end

    initial begin
        reset  = 1'b1;
        acki_n = 1'b1;
        ackd_n = 1'b1;
        ipend  = 1'b0;
        dpend  = 1'b0;
        ftake  = 1'b0;
        dtake  = 1'b0;
        idelay = 0;
        ddelay = 0;
        cycles = 0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_byte(data_base + i);
        end
        gen_program();
        for (int i = 0; i < 256; i++) begin
            chk.prog[i] = imem[i];  // checker keeps its own copy
            chk.mem[i]  = dmem[i];
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        while (!chk.done && cycles < limit) @(negedge clk);
        if (!chk.done) chk.report_timeout(cycles);
        chk.report();
        if (chk.errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/cpu_pkg.sv
verilog/ctrl_if.sv
verilog/decoder.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/ctrl_datapath.sv
verilog/top.sv
verif/tb_asserts.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- Makefile
TOP = tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top $(TOP) -f build.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
